// File: verilog/pipe_settings.svh
// Pipeline widths and levels
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// datapath
`define DATA_WIDTH 32
`define REG_NUM_WIDTH 5

// stage levels
`define E_LEVEL_NUM 1
`define M_LEVEL_NUM 2
`define LEVEL_WIDTH 3

`endif

// File: verilog/ctrlPkg.sv
// Execute control encodings
`include "pipe_settings.svh"

package ctrlPkg;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opNor  = 4'd5,
        opSlt  = 4'd6,
        opSltu = 4'd7,
        opSll  = 4'd8,   // shift by shamt
        opSrl  = 4'd9,
        opSra  = 4'd10,
        opSllv = 4'd11,  // shift by rs
        opSrlv = 4'd12,
        opSrav = 4'd13,
        opLui  = 4'd14
    } aluOpT;

    // writeback source
    typedef enum logic [1:0] {
        wdAlu  = 2'd0,
        wdMem  = 2'd1,
        wdLink = 2'd2
    } wdSelT;

    typedef struct packed {
        logic                      aluIn2Sel;      // 1 = immediate
        aluOpT                     aluOp;
        logic                      dmWriteEnable;
        logic [2:0]                dmDataType;     // for the memory stage
        logic                      rfWriteEnable;
        logic [`REG_NUM_WIDTH-1:0] rfWriteTarget;
        wdSelT                     rfWdSel;
        logic [`LEVEL_WIDTH-1:0]   resultSince;    // 1 alu/link, 2 load
    } execCtrl;

endpackage

// File: verilog/stagePkg.sv
// Stage payload types
`include "pipe_settings.svh"

package stagePkg;

    // ID/EX contents
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]    pc;
        logic [`DATA_WIDTH-1:0]    inst;
        logic [`REG_NUM_WIDTH-1:0] rsNum;
        logic [`DATA_WIDTH-1:0]    rsData;
        logic [`REG_NUM_WIDTH-1:0] rtNum;
        logic [`DATA_WIDTH-1:0]    rtData;
        logic [`DATA_WIDTH-1:0]    imm32;
        logic [4:0]                shamt;
        ctrlPkg::execCtrl          ctrl;
    } deBundle;

    // EX/MEM contents
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]    pc;
        logic [`DATA_WIDTH-1:0]    inst;
        logic [`DATA_WIDTH-1:0]    result;
        logic [`DATA_WIDTH-1:0]    storeData;
        logic                      dmWriteEnable;
        logic [2:0]                dmDataType;
        logic                      rfWriteEnable;
        logic [`REG_NUM_WIDTH-1:0] rfWriteTarget;
        ctrlPkg::wdSelT            rfWdSel;
        logic [`LEVEL_WIDTH-1:0]   resultSince;
    } emBundle;

    // register file write from writeback
    typedef struct packed {
        logic                      writeEnable;
        logic [`REG_NUM_WIDTH-1:0] target;
        logic [`DATA_WIDTH-1:0]    data;
    } wbBus;

endpackage

// File: verilog/pipeReg.sv
// Generic pipeline stage register
`timescale 1ns/1ns
`include "pipe_settings.svh"

module pipeReg #(
    parameter type payloadT = logic [7:0],
    parameter int  levelNum = 1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    hold,
    input  payloadT                 dataIn,
    input  logic [`LEVEL_WIDTH-1:0] resultSince,
    output payloadT                 dataOut,
    output logic                    haveResult
);

    logic [`LEVEL_WIDTH-1:0] sinceQ;

    always_ff @(posedge clk) begin
        if (reset || clear) begin   // clear beats hold
            dataOut <= '0;
            sinceQ  <= '0;
        end else if (!hold) begin
            dataOut <= dataIn;
            sinceQ  <= resultSince;
        end
    end

    // a bubble (since 0) never has a result; otherwise the producing
    // stage must already lie behind this register
    assign haveResult = (sinceQ != '0) && (int'(sinceQ) < levelNum);

endmodule

// File: verilog/hazardUnit.sv
// Forwarding and hazard detection
`timescale 1ns/1ns
`include "pipe_settings.svh"

module hazardUnit (
    input  stagePkg::deBundle      deIn,
    input  stagePkg::emBundle      emIn,
    input  logic                   emHaveResult,
    input  stagePkg::wbBus         wbIn,
    input  logic                   stallM,
    output logic [`DATA_WIDTH-1:0] rsValue,
    output logic [`DATA_WIDTH-1:0] rtValue,
    output logic                   stallD,
    output logic                   bubbleM
);

    logic rsWait;
    logic rtWait;
    logic loadUse;

    function automatic logic [`DATA_WIDTH-1:0] pickOperand(
        input logic [`REG_NUM_WIDTH-1:0] num,
        input logic [`DATA_WIDTH-1:0]    decodeData,
        input stagePkg::emBundle         em,
        input logic                      emReady,
        input stagePkg::wbBus            wb
    );
        logic [`DATA_WIDTH-1:0] value;
        if (num == '0)
            value = '0;   // r0 is hardwired
        else if (em.rfWriteEnable && em.rfWriteTarget == num && emReady)
            value = em.result;
        else if (wb.writeEnable && wb.target == num)
            value = wb.data;
        else
            value = decodeData;
        return value;
    endfunction

    // producer sits in EX/MEM but its value is not there yet
    function automatic logic waitsOnMem(
        input logic [`REG_NUM_WIDTH-1:0] num,
        input stagePkg::emBundle         em,
        input logic                      emReady
    );
        return (num != '0) && em.rfWriteEnable && (em.rfWriteTarget == num) && !emReady;
    endfunction

    assign rsValue = pickOperand(deIn.rsNum, deIn.rsData, emIn, emHaveResult, wbIn);
    assign rtValue = pickOperand(deIn.rtNum, deIn.rtData, emIn, emHaveResult, wbIn);

    assign rsWait  = waitsOnMem(deIn.rsNum, emIn, emHaveResult);
    assign rtWait  = waitsOnMem(deIn.rtNum, emIn, emHaveResult);
    assign loadUse = rsWait || rtWait;

    assign stallD  = loadUse || stallM;
    assign bubbleM = loadUse && !stallM;   // a frozen EX/MEM keeps its load

endmodule

// File: verilog/executeUnit.sv
// Execute stage datapath
`timescale 1ns/1ns
`include "pipe_settings.svh"

module executeUnit (
    input  stagePkg::deBundle      deIn,
    input  logic [`DATA_WIDTH-1:0] rsValue,
    input  logic [`DATA_WIDTH-1:0] rtValue,
    output stagePkg::emBundle      emNext
);

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] linkAddr;
    logic [4:0]             varShift;

    assign opA      = rsValue;
    assign opB      = deIn.ctrl.aluIn2Sel ? deIn.imm32 : rtValue;
    assign varShift = rsValue[4:0];
    assign linkAddr = deIn.pc + `DATA_WIDTH'(8);   // past the delay slot

    always_comb begin
        aluOut = '0;
        case (deIn.ctrl.aluOp)
            ctrlPkg::opAdd:  aluOut = opA + opB;
            ctrlPkg::opSub:  aluOut = opA - opB;
            ctrlPkg::opAnd:  aluOut = opA & opB;
            ctrlPkg::opOr:   aluOut = opA | opB;
            ctrlPkg::opXor:  aluOut = opA ^ opB;
            ctrlPkg::opNor:  aluOut = ~(opA | opB);
            ctrlPkg::opSlt:  aluOut[0] = $signed(opA) < $signed(opB);
            ctrlPkg::opSltu: aluOut[0] = opA < opB;
            ctrlPkg::opSll:  aluOut = opB << deIn.shamt;
            ctrlPkg::opSrl:  aluOut = opB >> deIn.shamt;
            ctrlPkg::opSra:  aluOut = $signed(opB) >>> deIn.shamt;
            ctrlPkg::opSllv: aluOut = opB << varShift;
            ctrlPkg::opSrlv: aluOut = opB >> varShift;
            ctrlPkg::opSrav: aluOut = $signed(opB) >>> varShift;
            ctrlPkg::opLui:  aluOut = {deIn.imm32[15:0], 16'b0};
            default:         aluOut = '0;
        endcase
    end

    always_comb begin
        emNext.pc            = deIn.pc;
        emNext.inst          = deIn.inst;
        emNext.result        = (deIn.ctrl.rfWdSel == ctrlPkg::wdLink) ? linkAddr : aluOut;
        emNext.storeData     = rtValue;   // forwarded store value
        emNext.dmWriteEnable = deIn.ctrl.dmWriteEnable;
        emNext.dmDataType    = deIn.ctrl.dmDataType;
        emNext.rfWriteEnable = deIn.ctrl.rfWriteEnable;
        emNext.rfWriteTarget = deIn.ctrl.rfWriteTarget;
        emNext.rfWdSel       = deIn.ctrl.rfWdSel;
        emNext.resultSince   = deIn.ctrl.resultSince;
    end

endmodule

// File: verilog/execStage.sv
// Execute slice top level
`timescale 1ns/1ns
`include "pipe_settings.svh"

module execStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              clearE,
    input  logic              stallM,
    input  stagePkg::deBundle decodeIn,
    input  stagePkg::wbBus    wbIn,
    output stagePkg::emBundle memOut,
    output logic              memHaveResult,
    output logic              stallD
);

    stagePkg::deBundle      deOut;
    stagePkg::emBundle      emNext;
    logic [`DATA_WIDTH-1:0] rsValue;
    logic [`DATA_WIDTH-1:0] rtValue;
    logic                   bubbleM;

    // ID/EX
    pipeReg #(
        .payloadT (stagePkg::deBundle),
        .levelNum (`E_LEVEL_NUM)
    ) deReg (
        .clk         (clk),
        .reset       (reset),
        .clear       (clearE),
        .hold        (stallD),
        .dataIn      (decodeIn),
        .resultSince (decodeIn.ctrl.resultSince),
        .dataOut     (deOut),
        .haveResult  ()   // nothing computed before EX
    );

    hazardUnit hazardUnit_i (
        .deIn         (deOut),
        .emIn         (memOut),
        .emHaveResult (memHaveResult),
        .wbIn         (wbIn),
        .stallM       (stallM),
        .rsValue      (rsValue),
        .rtValue      (rtValue),
        .stallD       (stallD),
        .bubbleM      (bubbleM)
    );

    executeUnit executeUnit_i (
        .deIn    (deOut),
        .rsValue (rsValue),
        .rtValue (rtValue),
        .emNext  (emNext)
    );

    // EX/MEM
    pipeReg #(
        .payloadT (stagePkg::emBundle),
        .levelNum (`M_LEVEL_NUM)
    ) emReg (
        .clk         (clk),
        .reset       (reset),
        .clear       (bubbleM),
        .hold        (stallM),
        .dataIn      (emNext),
        .resultSince (emNext.resultSince),
        .dataOut     (memOut),
        .haveResult  (memHaveResult)
    );

endmodule

// File: bench/execModel.svh
// Execute slice reference model
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

stagePkg::deBundle mDe;   // ID/EX contents
stagePkg::emBundle mEm;   // EX/MEM contents

// alu and link values exist after EX, load data only after MEM
function automatic logic modelHasResult();
    return (mEm.resultSince != 0) && (mEm.resultSince < `M_LEVEL_NUM);
endfunction

function automatic logic pendingLoad(input logic [`REG_NUM_WIDTH-1:0] num);
    if (num == 0)
        return 1'b0;
    return mEm.rfWriteEnable && (mEm.rfWriteTarget == num) && !modelHasResult();
endfunction

function automatic logic modelLoadUse();
    return pendingLoad(mDe.rsNum) || pendingLoad(mDe.rtNum);
endfunction

function automatic logic modelStallD();
    return modelLoadUse() || stallM;
endfunction

// newest value wins, r0 stays zero
function automatic logic [`DATA_WIDTH-1:0] operandOf(
    input logic [`REG_NUM_WIDTH-1:0] num,
    input logic [`DATA_WIDTH-1:0]    regData
);
    if (num == 0)
        return '0;
    if (mEm.rfWriteEnable && mEm.rfWriteTarget == num && modelHasResult())
        return mEm.result;
    if (wbIn.writeEnable && wbIn.target == num)
        return wbIn.data;
    return regData;
endfunction

function automatic logic [`DATA_WIDTH-1:0] aluModel(
    input ctrlPkg::aluOpT         op,
    input logic [`DATA_WIDTH-1:0] a,
    input logic [`DATA_WIDTH-1:0] b,
    input logic [4:0]             sh,
    input logic [`DATA_WIDTH-1:0] imm
);
    logic [63:0] wide;
    wide = {{32{b[31]}}, b};   // sign fill for arithmetic shifts
    case (op)
        ctrlPkg::opAdd:  return a + b;
        ctrlPkg::opSub:  return a + ~b + 32'd1;
        ctrlPkg::opAnd:  return a & b;
        ctrlPkg::opOr:   return a | b;
        ctrlPkg::opXor:  return a ^ b;
        ctrlPkg::opNor:  return ~a & ~b;
        ctrlPkg::opSlt:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
        ctrlPkg::opSltu: return {31'b0, a < b};
        ctrlPkg::opSll:  return b << sh;
        ctrlPkg::opSrl:  return b >> sh;
        ctrlPkg::opSra:  return 32'(wide >> sh);
        ctrlPkg::opSllv: return b << a[4:0];
        ctrlPkg::opSrlv: return b >> a[4:0];
        ctrlPkg::opSrav: return 32'(wide >> a[4:0]);
        ctrlPkg::opLui:  return imm << 16;
        default:         return '0;
    endcase
endfunction

function automatic stagePkg::emBundle executeModel();
    stagePkg::emBundle em;
    logic [`DATA_WIDTH-1:0] rsV;
    logic [`DATA_WIDTH-1:0] rtV;
    logic [`DATA_WIDTH-1:0] opB;
    rsV = operandOf(mDe.rsNum, mDe.rsData);
    rtV = operandOf(mDe.rtNum, mDe.rtData);
    opB = mDe.ctrl.aluIn2Sel ? mDe.imm32 : rtV;
    em.pc            = mDe.pc;
    em.inst          = mDe.inst;
    em.result        = aluModel(mDe.ctrl.aluOp, rsV, opB, mDe.shamt, mDe.imm32);
    if (mDe.ctrl.rfWdSel == ctrlPkg::wdLink)
        em.result    = mDe.pc + 32'd8;   // return address
    em.storeData     = rtV;
    em.dmWriteEnable = mDe.ctrl.dmWriteEnable;
    em.dmDataType    = mDe.ctrl.dmDataType;
    em.rfWriteEnable = mDe.ctrl.rfWriteEnable;
    em.rfWriteTarget = mDe.ctrl.rfWriteTarget;
    em.rfWdSel       = mDe.ctrl.rfWdSel;
    em.resultSince   = mDe.ctrl.resultSince;
    return em;
endfunction

// one rising edge, using the state and inputs just before it
task automatic modelClockEdge(output logic accepted);
    stagePkg::deBundle deNext;
    stagePkg::emBundle emNext;
    logic loadUse;
    loadUse  = modelLoadUse();
    accepted = !(loadUse || stallM);
    emNext   = mEm;
    if (!stallM)
        emNext = loadUse ? '0 : executeModel();   // bubble behind a waiting load
    deNext = mDe;
    if (clearE)
        deNext = '0;
    else if (accepted)
        deNext = decodeIn;
    mDe = deNext;
    mEm = emNext;
endtask

`endif

// File: bench/execStageTb.sv
// Execute slice testbench
`timescale 1ns/1ns
`include "pipe_settings.svh"

module execStageTb;

    localparam int cycleCount  = 2000;
    localparam int resetCycles = 16;

    logic              clk = 1'b0;
    logic              reset;
    logic              clearE;
    logic              stallM;
    stagePkg::deBundle decodeIn;
    stagePkg::wbBus    wbIn;
    stagePkg::emBundle memOut;
    logic              memHaveResult;
    logic              stallD;

    logic [31:0]            rngState = 32'habba_fca0;
    logic [`DATA_WIDTH-1:0] pcNext;
    int                     checkCount = 0;
    int                     errorCount = 0;

    `include "execModel.svh"

    execStage execStage_i (
        .clk           (clk),
        .reset         (reset),
        .clearE        (clearE),
        .stallM        (stallM),
        .decodeIn      (decodeIn),
        .wbIn          (wbIn),
        .memOut        (memOut),
        .memHaveResult (memHaveResult),
        .stallD        (stallD)
    );

    always #10 clk = ~clk;   // 20 ns period

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic expectEqual(input string name, input logic [159:0] got,
                               input logic [159:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compareOutputs();
        expectEqual("memOut.pc", memOut.pc, mEm.pc);
        expectEqual("memOut.inst", memOut.inst, mEm.inst);
        expectEqual("memOut.result", memOut.result, mEm.result);
        expectEqual("memOut.storeData", memOut.storeData, mEm.storeData);
        expectEqual("memOut.dmWriteEnable", memOut.dmWriteEnable, mEm.dmWriteEnable);
        expectEqual("memOut.dmDataType", memOut.dmDataType, mEm.dmDataType);
        expectEqual("memOut.rfWriteEnable", memOut.rfWriteEnable, mEm.rfWriteEnable);
        expectEqual("memOut.rfWriteTarget", memOut.rfWriteTarget, mEm.rfWriteTarget);
        expectEqual("memOut.rfWdSel", memOut.rfWdSel, mEm.rfWdSel);
        expectEqual("memOut.resultSince", memOut.resultSince, mEm.resultSince);
        expectEqual("memHaveResult", memHaveResult, modelHasResult());
        expectEqual("stallD", stallD, modelStallD());
    endtask

    // registers 0..3 only, so hazards come up often
    task automatic makeInstruction();
        logic [31:0] r;
        r = nextRandom();
        decodeIn.pc     = pcNext;
        pcNext          = pcNext + 32'd4;
        decodeIn.inst   = nextRandom();
        decodeIn.rsNum  = r[1:0];
        decodeIn.rtNum  = r[3:2];
        decodeIn.rsData = nextRandom();
        decodeIn.rtData = nextRandom();
        decodeIn.imm32  = r[4] ? nextRandom() : {{16{r[31]}}, r[31:16]};
        decodeIn.shamt  = r[9:5];
        decodeIn.ctrl.aluIn2Sel     = r[10];
        decodeIn.ctrl.aluOp         = ctrlPkg::aluOpT'(r[15:12] % 4'd15);
        decodeIn.ctrl.dmWriteEnable = (r[18:16] == 3'd0);
        decodeIn.ctrl.dmDataType    = r[21:19];
        decodeIn.ctrl.rfWriteEnable = (r[23:22] != 2'd0);
        decodeIn.ctrl.rfWriteTarget = r[25:24];
        case (r[28:26])
            3'd0, 3'd1: decodeIn.ctrl.rfWdSel = ctrlPkg::wdMem;   // load
            3'd2:       decodeIn.ctrl.rfWdSel = ctrlPkg::wdLink;
            default:    decodeIn.ctrl.rfWdSel = ctrlPkg::wdAlu;
        endcase
        decodeIn.ctrl.resultSince = (decodeIn.ctrl.rfWdSel == ctrlPkg::wdMem) ? 3'd2 : 3'd1;
    endtask

    task automatic driveControls();
        logic [31:0] r;
        r = nextRandom();
        stallM           = (r[2:0] == 3'd0);
        clearE           = (r[6:3] == 4'd0);
        wbIn.writeEnable = r[7];
        wbIn.target      = r[9:8];
        wbIn.data        = nextRandom();
    endtask

    initial begin
        logic accepted;
        reset    = 1'b1;
        clearE   = 1'b0;
        stallM   = 1'b0;
        decodeIn = '0;
        wbIn     = '0;
        mDe      = '0;
        mEm      = '0;
        pcNext   = 32'h0040_0000;
        repeat (resetCycles) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        expectEqual("memOut", memOut, '0);
        expectEqual("stallD", stallD, 1'b0);
        expectEqual("memHaveResult", memHaveResult, 1'b0);
        repeat (cycleCount) begin
            @(posedge clk);
            modelClockEdge(accepted);
            #2;
            if (accepted)
                makeInstruction();   // decode moves on only when taken
            driveControls();
            @(negedge clk);
            compareOutputs();
        end
        $display("checks: %0d  errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #((resetCycles + cycleCount + 50) * 20);
        $display("watchdog expired before the test loop finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: compile.f
+incdir+verilog
+incdir+bench
verilog/ctrlPkg.sv
verilog/stagePkg.sv
verilog/pipeReg.sv
verilog/hazardUnit.sv
verilog/executeUnit.sv
verilog/execStage.sv
bench/execStageTb.sv
